// ==== hdl/zx_paging_pkg.sv ====
// Shared types and address constants for the paging and ULA-port unit.
// RTL files reach into this package with scoped names.
package zx_paging_pkg;

	//============================================================
	// Machine model
	//============================================================

	// Latched from the mem_model input while reset is high
	typedef enum logic [1:0] {
		MODEL_48K   = 2'd0,
		MODEL_128K  = 2'd1,
		MODEL_PLUS3 = 2'd2
	} mem_model_e;

	//============================================================
	// Bus and event types
	//============================================================

	// CPU bus after strobe decoding
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;   // CPU write data
		logic        io_wr;  // Already qualified with M1 inactive
		logic        mem_rd;
		logic        mem_wr;
	} cpu_bus_t;

	// One decoded I/O write, valid for one cycle
	typedef struct packed {
		logic       wr_7ffd;
		logic       wr_1ffd;
		logic       wr_ula;
		logic [7:0] data;
		logic       addr14;  // +3 needs it for the full 7FFD decode
	} port_event_t;

	// Physical memory request
	typedef struct packed {
		logic [20:0] addr;  // Byte address
		logic        rd;
		logic        we;    // Already write-protected for ROM
		logic        is_rom;
	} mem_req_t;

	//============================================================
	// Physical address layout
	//============================================================

	// ROM space is {ROM_REGION, rom page, addr[13:0]}
	localparam logic [2:0] ROM_REGION = 3'b101;

	// RAM space is {RAM_REGION, ram page, addr[13:0]}
	localparam logic [3:0] RAM_REGION = 4'b0000;

	localparam logic [3:0] ROM_PAGE_48K       = 4'b1111;
	localparam logic [2:0] PAGE_SCREEN_NORMAL = 3'd5;  // Bank 1
	localparam logic [2:0] PAGE_BANK2         = 3'd2;  // Bank 2

endpackage

// ==== hdl/zx_port_decode.sv ====
// Edge-detects CPU I/O writes and sorts them into 7FFD, 1FFD and ULA events.
// Event strobes are one cycle wide and carry the data sampled at the edge.
module zx_port_decode (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  zx_paging_pkg::cpu_bus_t    bus,
	input  zx_paging_pkg::mem_model_e  model,
	output zx_paging_pkg::port_event_t evt
);

	logic       io_wr_q;     // Previous io_wr for edge detection
	logic       io_wr_rise;
	logic       is_plus3;
	logic       hit_7ffd;
	logic       hit_1ffd;
	logic       hit_ula;

	logic [2:0] strobe_q;    // {7ffd, 1ffd, ula}
	logic [7:0] data_q;
	logic       addr14_q;

	//============================================================
	// Partial address decode
	//============================================================

	assign is_plus3   = (model == zx_paging_pkg::MODEL_PLUS3);
	assign io_wr_rise = bus.io_wr & ~io_wr_q;

	// Base 7FFD match; the +3 also wants A14 high, checked against addr14
	assign hit_7ffd = ~bus.addr[15] & ~bus.addr[1];

	// 1FFD exists on the +3 only
	assign hit_1ffd = is_plus3 & ~bus.addr[1] & bus.addr[12]
		& (bus.addr[15:13] == 3'b000);

	assign hit_ula = ~bus.addr[0];  // Any even port

	//============================================================
	// Event register
	//============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			strobe_q <= 3'b000;
		end else begin
			io_wr_q  <= bus.io_wr;
			strobe_q <= {hit_7ffd, hit_1ffd, hit_ula} & {3{io_wr_rise}};
		end
	end

	// Payload captured once so later bus changes cannot disturb it
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			data_q   <= bus.dout;
			addr14_q <= bus.addr[14];
		end
	end

	assign evt.wr_7ffd = strobe_q[2];
	assign evt.wr_1ffd = strobe_q[1];
	assign evt.wr_ula  = strobe_q[0];
	assign evt.data    = data_q;
	assign evt.addr14  = addr14_q;

endmodule

// ==== hdl/zx_port_registers.sv ====
// Paging, ULA-port and memory-model registers, updated from decoded port events.
// The paging registers freeze once the lock is set, until the next reset.
module zx_port_registers (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  zx_paging_pkg::mem_model_e  mem_model,
	input  zx_paging_pkg::port_event_t evt,
	output zx_paging_pkg::mem_model_e  model,
	output logic [7:0]                 page_reg,
	output logic [7:0]                 page_reg_plus3,
	output logic                       paging_locked,
	output logic [2:0]                 border_color,
	output logic                       ear_out,
	output logic                       mic_out
);

	logic model_48k;
	logic model_plus3;
	logic load_7ffd;
	logic load_1ffd;

	assign model_48k   = (model == zx_paging_pkg::MODEL_48K);
	assign model_plus3 = (model == zx_paging_pkg::MODEL_PLUS3);

	//============================================================
	// Lock and write qualification
	//============================================================

	// 48K never pages; otherwise 7FFD bit 5 locks until reset
	assign paging_locked = model_48k | page_reg[5];

	// On the +3 the 7FFD port also needs A14 high
	assign load_7ffd = evt.wr_7ffd & ~paging_locked
		& (evt.addr14 | ~model_plus3);

	assign load_1ffd = evt.wr_1ffd & ~paging_locked;

	//============================================================
	// Model latch and paging registers
	//============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model          <= mem_model;  // Tracks the input during reset
			page_reg       <= 8'h00;
			page_reg_plus3 <= 8'h00;
		end else begin
			if (load_7ffd) begin
				page_reg <= evt.data;
			end
			if (load_1ffd) begin
				page_reg_plus3 <= evt.data;
			end
		end
	end

	//============================================================
	// ULA port
	//============================================================

	// Border and audio bits ignore the paging lock
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			mic_out      <= 1'b0;
			ear_out      <= 1'b0;
		end else if (evt.wr_ula) begin
			border_color <= evt.data[2:0];
			mic_out      <= evt.data[3];
			ear_out      <= evt.data[4];
		end
	end

endmodule

// ==== hdl/zx_address_map.sv ====
// Combinational map from CPU address to physical ROM/RAM address.
// Covers ROM selection, bank mapping, +3 all-RAM modes and ROM write protect.
module zx_address_map (
	input  zx_paging_pkg::cpu_bus_t   bus,
	input  zx_paging_pkg::mem_model_e model,
	input  logic [7:0]                page_reg,
	input  logic [7:0]                page_reg_plus3,
	output zx_paging_pkg::mem_req_t   mem
);

	logic [1:0]  bank;
	logic [13:0] offset;
	logic        special;       // +3 all-RAM mode
	logic [3:0]  rom_page;
	logic [2:0]  special_page;
	logic [20:0] phys_addr;
	logic        rom_access;

	assign bank   = bus.addr[15:14];
	assign offset = bus.addr[13:0];

	assign special = page_reg_plus3[0] & (model == zx_paging_pkg::MODEL_PLUS3);

	//============================================================
	// ROM page
	//============================================================

	always_comb begin
		case (model)
			zx_paging_pkg::MODEL_128K:  rom_page = {3'b011, page_reg[4]};
			zx_paging_pkg::MODEL_PLUS3: rom_page = {2'b10, page_reg_plus3[2], page_reg[4]};
			default:                    rom_page = zx_paging_pkg::ROM_PAGE_48K;
		endcase
	end

	//============================================================
	// Special mode layouts
	//============================================================

	always_comb begin
		case ({page_reg_plus3[2:1], bank})
			4'b00_00: special_page = 3'd0;
			4'b00_01: special_page = 3'd1;
			4'b00_10: special_page = 3'd2;
			4'b00_11: special_page = 3'd3;
			4'b01_00: special_page = 3'd4;
			4'b01_01: special_page = 3'd5;
			4'b01_10: special_page = 3'd6;
			4'b01_11: special_page = 3'd7;
			4'b10_00: special_page = 3'd4;
			4'b10_01: special_page = 3'd5;
			4'b10_10: special_page = 3'd6;
			4'b10_11: special_page = 3'd3;
			4'b11_00: special_page = 3'd4;
			4'b11_01: special_page = 3'd7;
			4'b11_10: special_page = 3'd6;
			default:  special_page = 3'd3;  // Layout 11, bank 3
		endcase
	end

	//============================================================
	// Physical address
	//============================================================

	assign rom_access = ~special & (bank == 2'b00);

	always_comb begin
		if (special) begin
			phys_addr = {zx_paging_pkg::RAM_REGION, special_page, offset};
		end else begin
			case (bank)
				2'b00: phys_addr = {zx_paging_pkg::ROM_REGION, rom_page, offset};
				2'b01: phys_addr = {zx_paging_pkg::RAM_REGION,
					zx_paging_pkg::PAGE_SCREEN_NORMAL, offset};
				2'b10: phys_addr = {zx_paging_pkg::RAM_REGION,
					zx_paging_pkg::PAGE_BANK2, offset};
				default: phys_addr = {zx_paging_pkg::RAM_REGION, page_reg[2:0], offset};
			endcase
		end
	end

	assign mem.addr   = phys_addr;
	assign mem.rd     = bus.mem_rd;
	assign mem.we     = bus.mem_wr & ~rom_access;  // ROM is write protected
	assign mem.is_rom = rom_access;

endmodule

// ==== hdl/zx_memory_mapper.sv ====
// Top level of the paging and ULA-port unit.
// Port decode feeds the registers, which steer the combinational address map.
module zx_memory_mapper (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  zx_paging_pkg::mem_model_e mem_model,
	input  zx_paging_pkg::cpu_bus_t   bus,
	output zx_paging_pkg::mem_req_t   mem,
	output logic [2:0]                border_color,
	output logic                      ear_out,
	output logic                      mic_out,
	output logic                      screen_page,
	output logic                      paging_locked
);

	zx_paging_pkg::port_event_t evt;
	zx_paging_pkg::mem_model_e  model;     // Model latched at reset
	logic [7:0]                 page_reg;  // 7FFD
	logic [7:0]                 page_reg_plus3;  // 1FFD

	zx_port_decode dec0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.model   (model),
		.evt     (evt)
	);

	zx_port_registers regs0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.mem_model      (mem_model),
		.evt            (evt),
		.model          (model),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.paging_locked  (paging_locked),
		.border_color   (border_color),
		.ear_out        (ear_out),
		.mic_out        (mic_out)
	);

	zx_address_map map0 (
		.bus            (bus),
		.model          (model),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.mem            (mem)
	);

	assign screen_page = page_reg[3];  // Shadow screen select for video

endmodule

// ==== verification/tb_zx_memory_mapper.sv ====
// Table-driven testbench for the paging and ULA-port unit.
// Each row applies an optional I/O write, then one memory access that is checked.
module tb_zx_memory_mapper;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          RESET_CYCLES = 10;
	localparam int          SETTLE_LIMIT = 4;   // Cycles allowed for register effects
	localparam logic [5:0]  NUM_ROWS     = 6'd36;
	localparam int unsigned SEED         = 32'h66ee_4b35;

	localparam zx_paging_pkg::mem_model_e M48 = zx_paging_pkg::MODEL_48K;
	localparam zx_paging_pkg::mem_model_e M128 = zx_paging_pkg::MODEL_128K;
	localparam zx_paging_pkg::mem_model_e MP3 = zx_paging_pkg::MODEL_PLUS3;

	typedef struct packed {
		logic [2:0]                ctl;        // {force reset, io write, random data}
		zx_paging_pkg::mem_model_e model;
		logic [15:0]               io_addr;
		logic [7:0]                io_data;
		logic [15:0]               mem_addr;   // Only the bank bits are used
		logic                      mem_wr;     // 1 write, 0 read
		logic [6:0]                exp_page;   // Physical address bits above [13:0]
		logic [3:0]                exp_flags;  // {we, is_rom, paging_locked, screen_page}
	} row_t;

	logic                      clk_sys;
	logic                      reset;
	zx_paging_pkg::mem_model_e mem_model;
	zx_paging_pkg::cpu_bus_t   bus;
	zx_paging_pkg::mem_req_t   mem;
	logic [2:0]                border_color;
	logic                      ear_out;
	logic                      mic_out;
	logic                      screen_page;
	logic                      paging_locked;

	row_t                      rows [NUM_ROWS];
	zx_paging_pkg::mem_model_e cur_model;
	logic [2:0]                exp_border;  // Expected ULA port state
	logic                      exp_mic;
	logic                      exp_ear;
	int                        fail_count;

	zx_memory_mapper dut0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.mem_model     (mem_model),
		.bus           (bus),
		.mem           (mem),
		.border_color  (border_color),
		.ear_out       (ear_out),
		.mic_out       (mic_out),
		.screen_page   (screen_page),
		.paging_locked (paging_locked)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//============================================================
	// Helpers
	//============================================================

	function automatic logic [6:0] rom_pg(input logic [3:0] page);
		return {3'b101, page};
	endfunction

	function automatic logic [6:0] ram_pg(input logic [2:0] page);
		return {4'b0000, page};
	endfunction

	function automatic logic regs_match(input logic exp_locked, input logic exp_screen);
		return (paging_locked === exp_locked) && (screen_page === exp_screen)
			&& (border_color === exp_border) && (mic_out === exp_mic)
			&& (ear_out === exp_ear);
	endfunction

	task automatic report_failure();
		fail_count++;
		$display("Test failures found");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0d ns: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			report_failure();
		end
	endtask

	task automatic next_drive_slot();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wait_settled(input logic exp_locked, input logic exp_screen);
		int cycles;
		cycles = 0;
		while (!regs_match(exp_locked, exp_screen)) begin
			if (cycles >= SETTLE_LIMIT) begin
				$display("Timeout at %0d ns: register outputs did not settle in %0d cycles",
					$time, SETTLE_LIMIT);
				report_failure();
			end else begin
				@(posedge clk_sys);
				#1;
				cycles++;
			end
		end
	endtask

	task automatic apply_reset(input zx_paging_pkg::mem_model_e model);
		next_drive_slot();
		reset     = 1'b1;
		mem_model = model;  // Latched by the DUT during reset
		bus       = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2;
		reset      = 1'b0;
		cur_model  = model;
		exp_border = 3'd0;
		exp_mic    = 1'b0;
		exp_ear    = 1'b0;
		wait_settled(model == zx_paging_pkg::MODEL_48K, 1'b0);
	endtask

	//============================================================
	// Stimulus table
	//============================================================

	// ctl, model, io_addr, io_data, mem_addr, mem_wr, exp_page, {we, rom, locked, screen}
	task automatic fill_table();
		// 48K, always locked
		rows[0]  = '{3'b100, M48, 16'h0000, 8'h00, 16'h0000, 1'b1, rom_pg(4'hF), 4'b0110};
		rows[1]  = '{3'b000, M48, 16'h0000, 8'h00, 16'h4000, 1'b1, ram_pg(3'd5), 4'b1010};
		rows[2]  = '{3'b000, M48, 16'h0000, 8'h00, 16'h8000, 1'b1, ram_pg(3'd2), 4'b1010};
		rows[3]  = '{3'b010, M48, 16'h7FFD, 8'h1F, 16'hC000, 1'b1, ram_pg(3'd0), 4'b1010};
		rows[4]  = '{3'b011, M48, 16'h00FE, 8'h00, 16'h0000, 1'b0, rom_pg(4'hF), 4'b0110};
		// 128K banking and partial decode
		rows[5]  = '{3'b010, M128, 16'h7FFD, 8'h13, 16'h0000, 1'b0, rom_pg(4'h7), 4'b0100};
		rows[6]  = '{3'b000, M128, 16'h0000, 8'h00, 16'hC000, 1'b1, ram_pg(3'd3), 4'b1000};
		rows[7]  = '{3'b010, M128, 16'h3FFD, 8'h0E, 16'hC000, 1'b1, ram_pg(3'd6), 4'b1001};
		rows[8]  = '{3'b000, M128, 16'h0000, 8'h00, 16'h0000, 1'b1, rom_pg(4'h6), 4'b0101};
		rows[9]  = '{3'b000, M128, 16'h0000, 8'h00, 16'h4000, 1'b0, ram_pg(3'd5), 4'b0001};
		// Lock by 7FFD bit 5, cleared only by reset
		rows[10] = '{3'b010, M128, 16'h7FFD, 8'h24, 16'hC000, 1'b1, ram_pg(3'd4), 4'b1010};
		rows[11] = '{3'b010, M128, 16'h7FFD, 8'h1B, 16'hC000, 1'b0, ram_pg(3'd4), 4'b0010};
		rows[12] = '{3'b000, M128, 16'h0000, 8'h00, 16'h0000, 1'b1, rom_pg(4'h6), 4'b0110};
		rows[13] = '{3'b100, M128, 16'h0000, 8'h00, 16'hC000, 1'b1, ram_pg(3'd0), 4'b1000};
		rows[14] = '{3'b010, M128, 16'h7FFD, 8'h11, 16'hC000, 1'b0, ram_pg(3'd1), 4'b0000};
		rows[15] = '{3'b000, M128, 16'h0000, 8'h00, 16'h0000, 1'b0, rom_pg(4'h7), 4'b0100};
		// +3 decode, ROM selection and all-RAM layouts
		rows[16] = '{3'b010, MP3, 16'h3FFD, 8'h0F, 16'hC000, 1'b0, ram_pg(3'd0), 4'b0000};
		rows[17] = '{3'b000, MP3, 16'h0000, 8'h00, 16'h0000, 1'b0, rom_pg(4'h8), 4'b0100};
		rows[18] = '{3'b010, MP3, 16'h7FFD, 8'h10, 16'h0000, 1'b0, rom_pg(4'h9), 4'b0100};
		rows[19] = '{3'b010, MP3, 16'h1FFD, 8'h04, 16'h0000, 1'b1, rom_pg(4'hB), 4'b0100};
		rows[20] = '{3'b010, MP3, 16'h1FFD, 8'h01, 16'h0000, 1'b1, ram_pg(3'd0), 4'b1000};
		rows[21] = '{3'b000, MP3, 16'h0000, 8'h00, 16'h4000, 1'b1, ram_pg(3'd1), 4'b1000};
		rows[22] = '{3'b000, MP3, 16'h0000, 8'h00, 16'h8000, 1'b1, ram_pg(3'd2), 4'b1000};
		rows[23] = '{3'b000, MP3, 16'h0000, 8'h00, 16'hC000, 1'b1, ram_pg(3'd3), 4'b1000};
		rows[24] = '{3'b010, MP3, 16'h1FFD, 8'h03, 16'h0000, 1'b1, ram_pg(3'd4), 4'b1000};
		rows[25] = '{3'b000, MP3, 16'h0000, 8'h00, 16'hC000, 1'b0, ram_pg(3'd7), 4'b0000};
		rows[26] = '{3'b010, MP3, 16'h1FFD, 8'h05, 16'h4000, 1'b1, ram_pg(3'd5), 4'b1000};
		rows[27] = '{3'b000, MP3, 16'h0000, 8'h00, 16'hC000, 1'b1, ram_pg(3'd3), 4'b1000};
		rows[28] = '{3'b010, MP3, 16'h1FFD, 8'h07, 16'h4000, 1'b0, ram_pg(3'd7), 4'b0000};
		rows[29] = '{3'b000, MP3, 16'h0000, 8'h00, 16'h8000, 1'b1, ram_pg(3'd6), 4'b1000};
		rows[30] = '{3'b000, MP3, 16'h0000, 8'h00, 16'h0000, 1'b1, ram_pg(3'd4), 4'b1000};
		rows[31] = '{3'b010, MP3, 16'h1FFD, 8'h00, 16'h0000, 1'b1, rom_pg(4'h9), 4'b0100};
		// ULA port while locked
		rows[32] = '{3'b010, MP3, 16'h7FFD, 8'h30, 16'hC000, 1'b0, ram_pg(3'd0), 4'b0010};
		rows[33] = '{3'b011, MP3, 16'h00FE, 8'h00, 16'h8000, 1'b1, ram_pg(3'd2), 4'b1010};
		rows[34] = '{3'b011, MP3, 16'h00FE, 8'h00, 16'h0000, 1'b0, rom_pg(4'h9), 4'b0110};
		rows[35] = '{3'b010, MP3, 16'h1FFD, 8'h01, 16'h0000, 1'b1, rom_pg(4'h9), 4'b0110};
	endtask

	//============================================================
	// Row execution
	//============================================================

	task automatic run_row(input row_t row);
		logic [13:0] offset;
		logic [7:0]  data;
		offset = 14'($urandom);
		data   = row.io_data;
		if (row.ctl[2] || (row.model != cur_model)) begin
			apply_reset(row.model);
		end
		if (row.ctl[1]) begin
			if (row.ctl[0]) begin
				data = 8'($urandom);
			end
			next_drive_slot();
			bus.addr   = row.io_addr;
			bus.dout   = data;
			bus.io_wr  = 1'b1;
			bus.mem_rd = 1'b0;
			bus.mem_wr = 1'b0;
			next_drive_slot();
			bus.dout = ~data;  // Data changes while the strobe is held
			next_drive_slot();
			next_drive_slot();
			bus.io_wr = 1'b0;
			if (row.io_addr[0] == 1'b0) begin
				exp_border = data[2:0];
				exp_mic    = data[3];
				exp_ear    = data[4];
			end
			wait_settled(row.exp_flags[1], row.exp_flags[0]);
			next_drive_slot();
		end
		next_drive_slot();

		// Memory access two cycles after the strobe is released
		bus.addr   = {row.mem_addr[15:14], offset};
		bus.dout   = 8'($urandom);
		bus.mem_rd = (row.mem_wr == 1'b0);
		bus.mem_wr = row.mem_wr;
		#10;
		compare("mem.addr", 32'(mem.addr), 32'({row.exp_page, offset}));
		compare("mem.rd", 32'(mem.rd), 32'(row.mem_wr == 1'b0));
		compare("mem.we", 32'(mem.we), 32'(row.exp_flags[3]));
		compare("mem.is_rom", 32'(mem.is_rom), 32'(row.exp_flags[2]));
		compare("paging_locked", 32'(paging_locked), 32'(row.exp_flags[1]));
		compare("screen_page", 32'(screen_page), 32'(row.exp_flags[0]));
		compare("border_color", 32'(border_color), 32'(exp_border));
		compare("mic_out", 32'(mic_out), 32'(exp_mic));
		compare("ear_out", 32'(ear_out), 32'(exp_ear));

		next_drive_slot();
		bus.mem_rd = 1'b0;
		bus.mem_wr = 1'b0;
		#10;
		compare("mem.we (idle bus)", 32'(mem.we), 32'd0);
	endtask

	initial begin
		logic [5:0] idx;
		reset      = 1'b1;
		mem_model  = zx_paging_pkg::MODEL_48K;
		bus        = '0;
		cur_model  = zx_paging_pkg::MODEL_48K;
		exp_border = 3'd0;
		exp_mic    = 1'b0;
		exp_ear    = 1'b0;
		fail_count = 0;
		void'($urandom(SEED));
		fill_table();
		for (idx = 6'd0; idx < NUM_ROWS; idx++) begin
			run_row(rows[idx]);
		end
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== zx_memory_mapper.f ====
hdl/zx_paging_pkg.sv
hdl/zx_port_decode.sv
hdl/zx_port_registers.sv
hdl/zx_address_map.sv
hdl/zx_memory_mapper.sv
verification/tb_zx_memory_mapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory mapper testbench with Verilator, run it and check the log.

set -u

cd "$(dirname "$0")" || {
	echo "Cannot enter the project directory"
	exit 1
}

TOP=tb_zx_memory_mapper
FILE_LIST=zx_memory_mapper.f
BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="Test failures found"

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator is not in PATH"
	exit 1
fi

verilator --binary --timing --timescale 1ns/100ps \
	--top-module "$TOP" --Mdir "$BUILD_DIR" -f "$FILE_LIST"
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
	echo "Simulation reported failures, see $LOG_FILE"
	exit 1
fi

if [ "$run_status" -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
